/* sim.f */
source/vit_pkg.sv
source/survivor_if.sv
source/branch_metric.sv
source/acs_unit.sv
source/trellis_mem.sv
source/traceback.sv
source/viterbi_dec.sv
verif/tb_viterbi.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"
verilator --binary --timing --assert -sv \
    --top-module tb_viterbi \
    --Mdir "$BUILD_DIR" \
    -o tb_viterbi \
    -f sim.f

"./$BUILD_DIR/tb_viterbi" | tee "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without a failure"

/* verif/tb_viterbi.sv */
`timescale 1ns/1ps

module tb_viterbi;

    import vit_pkg::*;

    localparam int TIMEOUT    = 40;   // cycles allowed per wait
    localparam int NUM_BLOCKS = 80;

    logic       clk;
    logic       rst;
    logic       i_sym_valid;
    logic [1:0] i_sym;
    logic       i_blk_end;
    logic       o_bit;
    logic       o_bit_valid;
    logic       o_bit_last;
    logic       o_busy;

    int         mismatches;
    int         failures;               // timeouts and protocol errors
    int         blk_no;
    bit         timed_out;
    bit         junk_on;                // strobe random symbols while busy
    logic       blk_bits [TB_DEPTH];    // encoder input including the tail
    logic [1:0] blk_syms [TB_DEPTH];    // received symbols
    int         blk_len;

    viterbi_dec i_viterbi_dec (
        .clk         (clk),
        .rst         (rst),
        .i_sym_valid (i_sym_valid),
        .i_sym       (i_sym),
        .i_blk_end   (i_blk_end),
        .o_bit       (o_bit),
        .o_bit_valid (o_bit_valid),
        .o_bit_last  (o_bit_last),
        .o_busy      (o_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    task automatic log_mismatch(input string name, input logic got, input logic exp);
        mismatches++;
        $display("MISMATCH at %0t: %s got %0b expected %0b (block %0d)",
                 $time, name, got, exp, blk_no);
    endtask

    task automatic log_failure(input string msg);
        failures++;
        $display("ERROR at %0t: %s (block %0d)", $time, msg, blk_no);
    endtask

    // reference encoder with state {newest, older}
    task automatic make_block(input int len, input bit flip);
        logic [STATE_BITS-1:0] st;
        logic                  g7;
        logic                  g5;
        int                    pos;
        logic                  bsel;
        st      = '0;
        blk_len = len;
        for (int k = 0; k < len; k++)
        begin
            blk_bits[k] = (k < len - 2) ? 1'($urandom) : 1'b0;  // two tail zeros
            g7          = blk_bits[k] ^ st[1] ^ st[0];
            g5          = blk_bits[k] ^ st[0];
            blk_syms[k] = {g7, g5};
            st          = {blk_bits[k], st[1]};
        end
        if (flip)
        begin
            pos  = $urandom_range(len - 1, 0);
            bsel = 1'($urandom);
            blk_syms[pos][bsel] = ~blk_syms[pos][bsel];  // one channel error
        end
    endtask

    task automatic send_block(input bit use_end);
        for (int k = 0; k < blk_len; k++)
        begin
            if (k > 0 && $urandom_range(3, 0) == 0)
            begin
                @(posedge clk);
                i_sym_valid <= 1'b0;  // idle gap
                i_blk_end   <= 1'b0;
            end
            @(posedge clk);
            i_sym_valid <= 1'b1;
            i_sym       <= blk_syms[k];
            i_blk_end   <= use_end && (k == blk_len - 1);
        end
        @(posedge clk);  // closing edge
        i_sym_valid <= 1'b0;
        i_blk_end   <= 1'b0;
    endtask

    task automatic drive_junk();
        i_sym_valid <= junk_on;
        i_sym       <= 2'($urandom);
        i_blk_end   <= 1'($urandom);
    endtask

    task automatic check_output();
        int   cycles;
        int   idx;
        logic exp_bit;
        for (cycles = 1; cycles <= TIMEOUT; cycles++)
        begin
            @(posedge clk);
            drive_junk();
            @(negedge clk);
            if (cycles == 1 && o_busy !== 1'b1)
            begin
                log_mismatch("o_busy", o_busy, 1'b1);
            end
            if (o_bit_valid === 1'b1)
            begin
                break;
            end
        end
        if (cycles > TIMEOUT)
        begin
            log_failure("timeout waiting for the first decoded bit");
            timed_out = 1'b1;
            return;
        end
        if (cycles != 2)
        begin
            log_failure($sformatf("first bit came %0d cycles after the closing edge", cycles));
        end

        for (idx = 0; idx < blk_len; idx++)
        begin
            if (idx > 0)
            begin
                @(posedge clk);
                drive_junk();
                @(negedge clk);
                if (o_bit_valid !== 1'b1)
                begin
                    log_failure($sformatf("output stopped after %0d of %0d bits",
                                          idx, blk_len));
                    break;
                end
            end
            exp_bit = blk_bits[blk_len - 1 - idx];  // newest bit first
            if (o_bit !== exp_bit)
            begin
                log_mismatch($sformatf("o_bit[%0d]", idx), o_bit, exp_bit);
            end
            if (o_bit_last !== (idx == blk_len - 1))
            begin
                log_mismatch($sformatf("o_bit_last[%0d]", idx), o_bit_last,
                             (idx == blk_len - 1));
            end
        end

        // busy drops one cycle after the last bit with no extra bits
        for (cycles = 1; cycles <= TIMEOUT; cycles++)
        begin
            @(posedge clk);
            i_sym_valid <= 1'b0;
            i_blk_end   <= 1'b0;
            @(negedge clk);
            if (o_bit_valid === 1'b1)
            begin
                log_failure("decoded bit beyond the block length");
            end
            if (o_busy === 1'b0)
            begin
                break;
            end
        end
        if (cycles > TIMEOUT)
        begin
            log_failure("timeout waiting for o_busy to fall");
            timed_out = 1'b1;
        end
        else if (cycles != 1)
        begin
            log_failure($sformatf("o_busy fell %0d cycles after the last bit", cycles));
        end
    endtask

    task automatic run_block(input int len, input bit flip, input bit use_end, input bit junk);
        make_block(len, flip);
        junk_on = junk;
        send_block(use_end);
        check_output();
        junk_on = 1'b0;
    endtask

    initial
    begin
        void'($urandom(89106));
        mismatches  = 0;
        failures    = 0;
        blk_no      = 0;
        timed_out   = 1'b0;
        junk_on     = 1'b0;
        blk_len     = 0;
        rst         = 1'b0;
        i_sym_valid = 1'b0;
        i_sym       = 2'b00;
        i_blk_end   = 1'b0;

        repeat (16) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        if (o_busy !== 1'b0)
        begin
            log_mismatch("o_busy", o_busy, 1'b0);
        end
        if (o_bit_valid !== 1'b0)
        begin
            log_mismatch("o_bit_valid", o_bit_valid, 1'b0);
        end
        if (o_bit_last !== 1'b0)
        begin
            log_mismatch("o_bit_last", o_bit_last, 1'b0);
        end

        for (int b = 0; b < NUM_BLOCKS && !timed_out; b++)
        begin
            blk_no = b;
            case (b % 4)
                0:       run_block($urandom_range(TB_DEPTH, 3), 1'b0, 1'b1, 1'b0);
                1:       run_block($urandom_range(TB_DEPTH, 3), 1'b1, 1'b1, 1'b0);
                2:       run_block(TB_DEPTH, 1'($urandom), 1'b0, 1'b0);  // self-closing
                default: run_block($urandom_range(TB_DEPTH, 3), 1'b0, 1'b1, 1'b1);
            endcase
        end

        $display("summary: %0d blocks, %0d mismatches, %0d other errors",
                 blk_no + 1, mismatches, failures);
        if (mismatches == 0 && failures == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* source/viterbi_dec.sv */
`timescale 1ns/1ps

module viterbi_dec (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_sym_valid,  // symbol strobe
    input  logic [1:0] i_sym,        // received {g7, g5}
    input  logic       i_blk_end,    // with the last symbol of a block
    output logic       o_bit,
    output logic       o_bit_valid,
    output logic       o_bit_last,
    output logic       o_busy        // strobes ignored while high
);

    logic            sym_accept;
    logic [3:0][1:0] bm;

    survivor_if sv_bus ();

    // symbols during read-back are dropped
    assign sym_accept = i_sym_valid & ~sv_bus.busy;
    assign o_busy     = sv_bus.busy;

    branch_metric i_branch_metric (
        .i_sym (i_sym),
        .o_bm  (bm)
    );

    acs_unit i_acs_unit (
        .clk         (clk),
        .rst         (rst),
        .i_sym_valid (sym_accept),
        .i_bm        (bm),
        .sv          (sv_bus.acs)
    );

    trellis_mem i_trellis_mem (
        .clk         (clk),
        .rst         (rst),
        .i_blk_end   (i_blk_end),
        .i_sym_valid (sym_accept),
        .sv          (sv_bus.mem)
    );

    traceback i_traceback (
        .clk         (clk),
        .rst         (rst),
        .sv          (sv_bus.tb),
        .o_bit       (o_bit),
        .o_bit_valid (o_bit_valid),
        .o_bit_last  (o_bit_last)
    );

endmodule

/* source/traceback.sv */
`timescale 1ns/1ps

module traceback (
    input  logic   clk,
    input  logic   rst,
    survivor_if.tb sv,
    output logic   o_bit,        // decoded bit, newest first
    output logic   o_bit_valid,
    output logic   o_bit_last    // oldest bit of the block
);

    import vit_pkg::*;

    tb_state_t             tb_state;
    logic [STATE_BITS-1:0] cur_state;    // state after the column in view
    logic [STATE_BITS-1:0] walk_state;

    // a terminated block always ends in state zero
    assign walk_state = sv.rd_first ? '0 : cur_state;

    // one column per cycle while walking
    assign sv.rd_en = (tb_state == TB_RUN);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            tb_state    <= TB_IDLE;
            o_bit_valid <= 1'b0;
            o_bit_last  <= 1'b0;
        end
        else
        begin
            o_bit_valid <= 1'b0;
            o_bit_last  <= 1'b0;
            case (tb_state)
                TB_IDLE:
                begin
                    if (sv.tb_start)
                    begin
                        tb_state <= TB_RUN;
                    end
                end
                TB_RUN:
                begin
                    o_bit_valid <= 1'b1;
                    o_bit_last  <= sv.rd_last;
                    if (sv.rd_last)
                    begin
                        tb_state <= TB_IDLE;
                    end
                end
                default:
                begin
                    tb_state <= TB_IDLE;
                end
            endcase
        end
    end

    // upper state bit is the input that led here
    // and the decision bit fills in the older bit of the predecessor
    always_ff @(posedge clk)
    begin
        if (tb_state == TB_RUN)
        begin
            o_bit     <= walk_state[STATE_BITS-1];
            cur_state <= {walk_state[STATE_BITS-2:0], sv.rd_dec[walk_state]};
        end
    end

    // the surviving path reaches back to the encoder's start state
    a_walk_home: assert property (
        @(posedge clk) disable iff (!rst)
        o_bit_last |-> (cur_state == '0)
    );

    // the memory must stay in read mode for the whole walk
    a_run_busy: assert property (
        @(posedge clk) disable iff (!rst)
        (tb_state == TB_RUN) |-> sv.busy
    );

endmodule

/* source/trellis_mem.sv */
`timescale 1ns/1ps

module trellis_mem (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_blk_end,    // last symbol of the block
    input  logic    i_sym_valid,  // accepted symbol
    survivor_if.mem sv
);

    import vit_pkg::*;

    logic [STATE_NUM-1:0]  dec_mem [TB_DEPTH];  // one column per symbol
    logic [DEPTH_BITS-1:0] depth;      // write index, then read index
    logic                  busy;       // read mode
    logic                  tb_start;
    logic                  rd_first;
    logic                  empty;      // oldest column consumed
    logic                  blk_close;

    // the 15th column closes the block even without i_blk_end
    assign blk_close = i_sym_valid &
                       (i_blk_end | (depth == DEPTH_BITS'(TB_DEPTH - 1)));

    always_ff @(posedge clk)
    begin
        if (sv.wr_en && !busy)
        begin
            dec_mem[depth] <= sv.wr_dec;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            depth    <= '0;
            busy     <= 1'b0;
            tb_start <= 1'b0;
            rd_first <= 1'b0;
            empty    <= 1'b0;
        end
        else
        begin
            tb_start <= 1'b0;
            if (empty)
            begin
                busy  <= 1'b0;   // back to fill mode
                empty <= 1'b0;
                depth <= '0;
            end
            else if (!busy)
            begin
                if (sv.wr_en)
                begin
                    if (blk_close)
                    begin
                        busy     <= 1'b1;  // depth stays on newest column
                        tb_start <= 1'b1;
                        rd_first <= 1'b1;
                    end
                    else
                    begin
                        depth <= depth + 1'b1;
                    end
                end
            end
            else if (sv.rd_en)
            begin
                rd_first <= 1'b0;
                if (depth == '0)
                begin
                    empty <= 1'b1;
                end
                else
                begin
                    depth <= depth - 1'b1;
                end
            end
        end
    end

    assign sv.rd_dec   = dec_mem[depth];
    assign sv.rd_first = rd_first;
    assign sv.rd_last  = busy & ~empty & (depth == '0);
    assign sv.tb_start = tb_start;
    assign sv.busy     = busy;

    a_depth_range: assert property (
        @(posedge clk) disable iff (!rst)
        depth < DEPTH_BITS'(TB_DEPTH)
    );

    // traceback may only pull columns once the block is closed
    a_no_rd_fill: assert property (
        @(posedge clk) disable iff (!rst)
        sv.rd_en |-> busy
    );

endmodule

/* source/acs_unit.sv */
`timescale 1ns/1ps

module acs_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_sym_valid,  // accepted symbol
    input  logic [3:0][1:0] i_bm,         // branch metric per code pair
    survivor_if.acs         sv
);

    import vit_pkg::*;

    logic [METRIC_BITS-1:0] pm      [STATE_NUM];  // path metrics
    logic [METRIC_BITS-1:0] pm_next [STATE_NUM];
    logic [STATE_NUM-1:0]   dec;                  // 1 = odd predecessor won

    // every next state n has predecessors {n[0], 0} and {n[0], 1}
    // and the input bit on both branches is n[1]
    for (genvar n = 0; n < STATE_NUM; n++)
    begin : g_acs
        logic [STATE_BITS-1:0]  nxt;
        logic [STATE_BITS-1:0]  pred0;
        logic [STATE_BITS-1:0]  pred1;
        logic [1:0]             pair0;   // code pair on branch from pred0
        logic [1:0]             pair1;
        logic [METRIC_BITS-1:0] cand0;
        logic [METRIC_BITS-1:0] cand1;

        assign nxt   = STATE_BITS'(n);
        assign pred0 = {nxt[STATE_BITS-2:0], 1'b0};
        assign pred1 = {nxt[STATE_BITS-2:0], 1'b1};

        // g7 = b ^ s1 ^ s0, g5 = b ^ s0 with b = nxt[1], s1 = nxt[0]
        assign pair0 = {nxt[1] ^ nxt[0], nxt[1]};
        assign pair1 = {~(nxt[1] ^ nxt[0]), ~nxt[1]};

        assign cand0 = pm[pred0] + METRIC_BITS'(i_bm[pair0]);
        assign cand1 = pm[pred1] + METRIC_BITS'(i_bm[pair1]);

        // ties go to the lower predecessor
        assign dec[n]     = (cand1 < cand0);
        assign pm_next[n] = dec[n] ? cand1 : cand0;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < STATE_NUM; i++)
            begin
                pm[i] <= (i == 0) ? '0 : METRIC_INIT;
            end
        end
        else if (sv.busy)
        begin
            // held at start values until read-back is over
            for (int i = 0; i < STATE_NUM; i++)
            begin
                pm[i] <= (i == 0) ? '0 : METRIC_INIT;
            end
        end
        else if (i_sym_valid)
        begin
            for (int i = 0; i < STATE_NUM; i++)
            begin
                pm[i] <= pm_next[i];
            end
        end
    end

    // decisions go out on the same edge the symbol is taken
    assign sv.wr_en  = i_sym_valid;
    assign sv.wr_dec = dec;

    // symbols are gated in the top level with busy from the memory
    a_no_wr_busy: assert property (
        @(posedge clk) disable iff (!rst)
        sv.wr_en |-> !sv.busy
    );

endmodule

/* source/branch_metric.sv */
`timescale 1ns/1ps

module branch_metric (
    input  logic [1:0]      i_sym,  // received {g7, g5}
    output logic [3:0][1:0] o_bm    // distance, indexed by code pair
);

    // Hamming distance from the received pair to every possible code pair
    // hard decisions only
    // a soft-decision version would replace just this block
    for (genvar p = 0; p < 4; p++)
    begin : g_pair
        logic [1:0] code;   // candidate code pair
        logic [1:0] diff;   // bits that disagree

        assign code = 2'(p);
        assign diff = i_sym ^ code;

        // count of set bits, 0 to 2
        assign o_bm[p] = {1'b0, diff[1]} + {1'b0, diff[0]};
    end

endmodule

/* source/survivor_if.sv */
`timescale 1ns/1ps

interface survivor_if;

    import vit_pkg::*;

    logic                  wr_en;     // decision column valid
    logic [STATE_NUM-1:0]  wr_dec;    // one decision bit per next state
    logic                  rd_en;     // traceback consumes a column
    logic [STATE_NUM-1:0]  rd_dec;    // column under the read pointer
    logic                  rd_first;  // newest column of the block
    logic                  rd_last;   // oldest column of the block
    logic                  tb_start;  // one cycle pulse when the block closes
    logic                  busy;      // read-back in progress

    modport acs (output wr_en, wr_dec, input busy);

    modport mem (
        input  wr_en, wr_dec, rd_en,
        output rd_dec, rd_first, rd_last, tb_start, busy
    );

    modport tb (output rd_en, input rd_dec, rd_first, rd_last, tb_start, busy);

endinterface

/* source/vit_pkg.sv */
package vit_pkg;

    // rate 1/2, K = 3, generators 7 and 5 (octal)
    //
    // state s = {s[1], s[0]} holds the two most recent input bits
    // with s[1] the newest one
    // input bit b from state s moves to state {b, s[1]}
    // code pair for b from s is {g7, g5} with
    //     g7 = b ^ s[1] ^ s[0]
    //     g5 = b ^ s[0]
    // g7 is the upper bit of a received symbol pair

    localparam int STATE_NUM   = 4;   // trellis states
    localparam int STATE_BITS  = 2;   // width of a state index

    // traceback depth and the longest block in symbols (5 * K)
    localparam int TB_DEPTH    = 15;
    localparam int DEPTH_BITS  = 4;   // column counter width

    // six bits hold 32 + 15 * 2 without wrapping
    localparam int METRIC_BITS = 6;

    // every state but zero starts far behind since the encoder starts in state 0
    localparam logic [METRIC_BITS-1:0] METRIC_INIT = METRIC_BITS'(32);

    // traceback controller
    typedef enum logic
    {
        TB_IDLE,   // waiting for a finished block
        TB_RUN     // walking columns backward
    } tb_state_t;

endpackage
